/* cfg_info_frame.f */
verilog/cfg_info_pkg.sv
verilog/cfg_frame_tracker.sv
verilog/cfg_limit_group.sv
verilog/cfg_info_frame.sv
verification/cfg_info_frame_assert.sv
verification/tb_cfg_info_frame.sv

/* Makefile */
TOP   := tb_cfg_info_frame
FLIST := cfg_info_frame.f
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f $(FLIST) --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/tb_cfg_info_frame.sv */
// Uses header lengths 16 and 40; expected table is rebuilt from the frame write rule
`default_nettype none
`timescale 1ns/10ps

module tb_cfg_info_frame;

    localparam int HDR_SHORT  = 16;
    localparam int HDR_LONG   = 40;
    localparam int NUM_WORDS  = cfg_info_pkg::NUM_GROUPS * cfg_info_pkg::WORDS_PER_GROUP;
    localparam int SETTLE_MAX = 12;

    logic                       clk_sys;
    logic                       rst_sys_n;
    logic                       slink_cfg_dval;
    cfg_info_pkg::cfg_symbol_t  slink_cfg_data;
    logic                       cfg_chaddr_sel;
    logic                       cfg_done;
    cfg_info_pkg::limit_table_t limits;

    cfg_info_pkg::limit_word_t  ref_words [NUM_WORDS];
    logic [31:0]                rng_state;
    int                         tests_run;
    int                         tests_failed;

    cfg_info_frame #(
        .HDR_LEN_SHORT  (HDR_SHORT),
        .HDR_LEN_LONG   (HDR_LONG)
    ) u_dut (
        .clk_sys        (clk_sys),
        .rst_sys_n      (rst_sys_n),
        .slink_cfg_dval (slink_cfg_dval),
        .slink_cfg_data (slink_cfg_data),
        .cfg_chaddr_sel (cfg_chaddr_sel),
        .cfg_done       (cfg_done),
        .limits         (limits)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------
    // Reference table
    // ----------------------------------------
    // Word n counts in frame order with six per group
    function automatic cfg_info_pkg::limit_word_t dut_word(input int n);
        int g;
        int w;
        g = n / cfg_info_pkg::WORDS_PER_GROUP;
        w = n % cfg_info_pkg::WORDS_PER_GROUP;
        case (g)
            0:       return limits.engn_ul[w];
            1:       return limits.engn_dl[w];
            2:       return limits.elec_ul[w];
            3:       return limits.elec_dl[w];
            4:       return limits.mnt_ul[w];
            default: return limits.mnt_dl[w];
        endcase
    endfunction

    function automatic int count_mismatch();
        int errs;
        errs = 0;
        for (int n = 0; n < NUM_WORDS; n++) begin
            if (dut_word(n) !== ref_words[n]) begin
                errs++;
            end
        end
        return errs;
    endfunction

    // Bytes outside the window after the header are dropped
    task automatic note_byte(input int k, input int base, input logic [7:0] data);
        int off;
        int g;
        int w;
        int l;
        off = k - base;
        if (off >= 0 && off < cfg_info_pkg::TABLE_BYTES) begin
            g = off / cfg_info_pkg::GROUP_BYTES;
            w = (off % cfg_info_pkg::GROUP_BYTES) / cfg_info_pkg::BYTES_PER_WORD;
            l = off % cfg_info_pkg::BYTES_PER_WORD;
            ref_words[g * cfg_info_pkg::WORDS_PER_GROUP + w][8 * (3 - l) +: 8] = data;
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic send_symbol(input logic sof, input logic [7:0] data, input int gap);
        @(posedge clk_sys);
        slink_cfg_dval <= 1'b1;
        slink_cfg_data <= '{rsvd: 1'b0, sof: sof, data: data};
        for (int i = 0; i < gap; i++) begin
            @(posedge clk_sys);
            slink_cfg_dval <= 1'b0;
        end
    endtask

    // Start symbol, then data symbols with indices 1 to last_idx
    task automatic send_frame(input logic sel, input int last_idx, input int gap,
                              input logic counted);
        logic [7:0] data;
        int         base;
        base = sel ? HDR_LONG : HDR_SHORT;
        @(posedge clk_sys);
        cfg_chaddr_sel <= sel;
        send_symbol(1'b1, 8'h5a, gap);
        for (int k = 1; k <= last_idx; k++) begin
            rng_state = xorshift32(rng_state);
            data      = rng_state[7:0];
            send_symbol(1'b0, data, gap);
            if (counted) begin
                note_byte(k, base, data);
            end
        end
        @(posedge clk_sys);
        slink_cfg_dval <= 1'b0;
    endtask

    // Waits for three matching samples in a row so late writes are seen
    task automatic check_table(input string name);
        int cyc;
        int stable;
        int errs;
        cyc    = 0;
        stable = 0;
        errs   = 0;
        while (stable < 3 && cyc < SETTLE_MAX) begin
            @(negedge clk_sys);
            cyc++;
            stable = (count_mismatch() == 0) ? stable + 1 : 0;
        end
        if (stable < 3) begin
            $display("Test %s: limits did not settle on the expected table within %0d cycles",
                     name, SETTLE_MAX);
            errs++;
        end
        for (int n = 0; n < NUM_WORDS; n++) begin
            if (dut_word(n) !== ref_words[n]) begin
                $display("FAIL %s word %0d: expected %h, actual %h",
                         name, n, ref_words[n], dut_word(n));
                errs++;
            end
        end
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %s finished with %0d mismatches", name, errs);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int assert_errs;
        rst_sys_n      <= 1'b0;
        slink_cfg_dval <= 1'b0;
        slink_cfg_data <= '0;
        cfg_chaddr_sel <= 1'b0;
        cfg_done       <= 1'b0;
        rng_state      = 32'd18;
        tests_run      = 0;
        tests_failed   = 0;
        for (int n = 0; n < NUM_WORDS; n++) begin
            ref_words[n] = '0;
        end
        repeat (10) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
        check_table("reset");

        send_frame(1'b0, 159, 0, 1'b1);
        check_table("base16");

        // Indices past 183 fall beyond the table
        send_frame(1'b1, 200, 2, 1'b1);
        check_table("base40_gaps");

        @(posedge clk_sys);
        cfg_done <= 1'b1;
        send_frame(1'b0, 170, 0, 1'b0);
        check_table("frozen");
        @(posedge clk_sys);
        cfg_done <= 1'b0;
        send_frame(1'b0, 159, 1, 1'b1);
        check_table("unfrozen");

        // Second start symbol cuts the first frame short
        send_frame(1'b1, 120, 0, 1'b1);
        send_frame(1'b1, 90, 0, 1'b1);
        check_table("restart");

        assert_errs = u_dut.u_assert.err_total;
        $display("Tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, assert_errs);
        if (tests_failed == 0 && assert_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/cfg_info_frame_assert.sv */
// Rebuilds the frame index from DUT ports; frames are assumed shorter than 512 symbols
`default_nettype none
`timescale 1ns/10ps

module cfg_info_frame_assert #(
    parameter int HDR_LEN_SHORT = 16,
    parameter int HDR_LEN_LONG  = 40
) (
    input wire                             clk_sys,
    input wire                             rst_sys_n,
    input wire                             slink_cfg_dval,
    input wire cfg_info_pkg::cfg_symbol_t  slink_cfg_data,
    input wire                             cfg_chaddr_sel,
    input wire                             cfg_done,
    input wire cfg_info_pkg::limit_table_t limits
);

    int         idx;
    int         nidx;
    int         base;
    logic       wr;
    logic       wr_d1;
    logic       wr_d2;
    int         off_d1;
    int         off_d2;
    logic [7:0] byte_d1;
    logic [7:0] byte_d2;
    logic       frz_d1;
    logic       frz_d2;
    int         byte_errs = 0;
    int         frz_errs  = 0;
    int         rst_errs  = 0;
    int         err_total;

    // Group 0 sits in the top 192 bits, lane 0 is bits 31:24 of a word
    function automatic logic [7:0] table_byte(input cfg_info_pkg::limit_table_t t,
                                              input int o);
        int pos;
        pos = 192 * (5 - o / 24) + 32 * ((o % 24) / 4) + 8 * (3 - o % 4);
        return t[pos +: 8];
    endfunction

    assign base = cfg_chaddr_sel ? HDR_LEN_LONG : HDR_LEN_SHORT;
    assign nidx = slink_cfg_data.sof ? 0 : idx + 1;
    assign wr   = slink_cfg_dval && !cfg_done && !slink_cfg_data.sof &&
                  nidx >= base && nidx < base + cfg_info_pkg::TABLE_BYTES;
    assign err_total = byte_errs + frz_errs + rst_errs;

    // ----------------------------------------
    // Port-side index and two-cycle delay
    // ----------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            idx     <= 0;
            wr_d1   <= 1'b0;
            wr_d2   <= 1'b0;
            off_d1  <= 0;
            off_d2  <= 0;
            byte_d1 <= '0;
            byte_d2 <= '0;
            frz_d1  <= 1'b0;
            frz_d2  <= 1'b0;
        end else begin
            if (slink_cfg_dval && !cfg_done) begin
                idx <= nidx;
            end
            wr_d1   <= wr;
            wr_d2   <= wr_d1;
            off_d1  <= nidx - base;
            off_d2  <= off_d1;
            byte_d1 <= slink_cfg_data.data;
            byte_d2 <= byte_d1;
            frz_d1  <= slink_cfg_dval && cfg_done;
            frz_d2  <= frz_d1;
        end
    end

    a_byte_write: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        wr_d2 |-> table_byte(limits, off_d2) == byte_d2)
    else begin
        byte_errs = byte_errs + 1;
        $error("Table byte at offset %0d does not hold the byte written", off_d2);
    end

    a_freeze: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        frz_d2 |-> $stable(limits))
    else begin
        frz_errs = frz_errs + 1;
        $error("Limits changed after a strobe while cfg_done was high");
    end

    a_reset_clear: assert property (@(posedge clk_sys)
        $rose(rst_sys_n) |-> limits == '0)
    else begin
        rst_errs = rst_errs + 1;
        $error("Limits not all zero after reset");
    end

endmodule

bind cfg_info_frame cfg_info_frame_assert #(
    .HDR_LEN_SHORT  (HDR_LEN_SHORT),
    .HDR_LEN_LONG   (HDR_LEN_LONG)
) u_assert (
    .clk_sys        (clk_sys),
    .rst_sys_n      (rst_sys_n),
    .slink_cfg_dval (slink_cfg_dval),
    .slink_cfg_data (slink_cfg_data),
    .cfg_chaddr_sel (cfg_chaddr_sel),
    .cfg_done       (cfg_done),
    .limits         (limits)
);

`default_nettype wire

/* verilog/cfg_info_frame.sv */
// Header lengths must satisfy base plus 144 within 9 bits; limits update 2 cycles after a strobe
`default_nettype none
`timescale 1ns/10ps

module cfg_info_frame #(
    parameter int HDR_LEN_SHORT = 16,
    parameter int HDR_LEN_LONG  = 40
) (
    input  wire                          clk_sys,
    input  wire                          rst_sys_n,
    input  wire                          slink_cfg_dval,
    input  wire cfg_info_pkg::cfg_symbol_t slink_cfg_data,
    input  wire                          cfg_chaddr_sel,
    input  wire                          cfg_done,
    output cfg_info_pkg::limit_table_t   limits
);

    cfg_info_pkg::group_sel_t    group_sel;
    cfg_info_pkg::word_index_t   word_index;
    cfg_info_pkg::byte_lane_t    byte_lane;
    logic [7:0]                  wr_byte;
    cfg_info_pkg::limit_group_t  grp_words [cfg_info_pkg::NUM_GROUPS];

    // ----------------------------------------
    // Index counter and write decode
    // ----------------------------------------
    cfg_frame_tracker #(
        .HDR_LEN_SHORT  (HDR_LEN_SHORT),
        .HDR_LEN_LONG   (HDR_LEN_LONG)
    ) u_tracker (
        .clk_sys        (clk_sys),
        .rst_sys_n      (rst_sys_n),
        .slink_cfg_dval (slink_cfg_dval),
        .slink_cfg_data (slink_cfg_data),
        .cfg_chaddr_sel (cfg_chaddr_sel),
        .cfg_done       (cfg_done),
        .group_sel      (group_sel),
        .word_index     (word_index),
        .byte_lane      (byte_lane),
        .wr_byte        (wr_byte)
    );

    // ----------------------------------------
    // Group stores, in frame order
    // ----------------------------------------
    for (genvar g = 0; g < cfg_info_pkg::NUM_GROUPS; g++) begin : g_group
        cfg_limit_group u_group (
            .clk_sys    (clk_sys),
            .rst_sys_n  (rst_sys_n),
            .wr_en      (group_sel[g]),
            .word_index (word_index),
            .byte_lane  (byte_lane),
            .wr_byte    (wr_byte),
            .words      (grp_words[g])
        );
    end

    // Group 0 is the first group after the header
    assign limits.engn_ul = grp_words[0];
    assign limits.engn_dl = grp_words[1];
    assign limits.elec_ul = grp_words[2];
    assign limits.elec_dl = grp_words[3];
    assign limits.mnt_ul  = grp_words[4];
    assign limits.mnt_dl  = grp_words[5];

endmodule

`default_nettype wire

/* verilog/cfg_limit_group.sv */
// Word and lane addresses above the group size are never issued by the tracker
`default_nettype none
`timescale 1ns/10ps

module cfg_limit_group (
    input  wire                         clk_sys,
    input  wire                         rst_sys_n,
    input  wire                         wr_en,
    input  wire cfg_info_pkg::word_index_t word_index,
    input  wire cfg_info_pkg::byte_lane_t  byte_lane,
    input  wire [7:0]                   wr_byte,
    output cfg_info_pkg::limit_group_t  words
);

    localparam int NUM_BYTES = cfg_info_pkg::WORDS_PER_GROUP * cfg_info_pkg::BYTES_PER_WORD;

    logic [NUM_BYTES-1:0] byte_en;
    logic [4:0]           byte_addr;

    // ----------------------------------------
    // Byte enable decode
    // ----------------------------------------
    // Word number times four plus lane
    assign byte_addr = {word_index, byte_lane};

    always_comb begin
        byte_en = '0;
        if (wr_en) begin
            byte_en = NUM_BYTES'(1) << byte_addr;
        end
    end

    // ----------------------------------------
    // Word storage
    // ----------------------------------------
    // Untouched lanes keep their old value,
    // so a partial frame only patches what it carries
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            words <= '0;
        end else begin
            for (int w = 0; w < cfg_info_pkg::WORDS_PER_GROUP; w++) begin
                for (int b = 0; b < cfg_info_pkg::BYTES_PER_WORD; b++) begin
                    if (byte_en[w*cfg_info_pkg::BYTES_PER_WORD + b]) begin
                        // Lane 0 goes to bits 31:24
                        words[w][8*(cfg_info_pkg::BYTES_PER_WORD-1-b) +: 8] <= wr_byte;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cfg_frame_tracker.sv */
// Base index plus 144 must fit in 9 bits; no back-pressure, every strobe is consumed
`default_nettype none
`timescale 1ns/10ps

module cfg_frame_tracker #(
    parameter int HDR_LEN_SHORT = 16,
    parameter int HDR_LEN_LONG  = 40
) (
    input  wire                        clk_sys,
    input  wire                        rst_sys_n,
    input  wire                        slink_cfg_dval,
    input  wire cfg_info_pkg::cfg_symbol_t slink_cfg_data,
    input  wire                        cfg_chaddr_sel,
    input  wire                        cfg_done,
    output cfg_info_pkg::group_sel_t   group_sel,
    output cfg_info_pkg::word_index_t  word_index,
    output cfg_info_pkg::byte_lane_t   byte_lane,
    output logic [7:0]                 wr_byte
);

    cfg_info_pkg::frame_index_t idx_q;
    cfg_info_pkg::frame_index_t idx_next;
    cfg_info_pkg::frame_index_t base;
    cfg_info_pkg::frame_index_t win_off;
    logic [2:0]                 grp_num;
    logic [4:0]                 grp_byte;
    logic                       accept;
    logic                       in_window;
    logic                       wr_ok;

    // ----------------------------------------
    // Frame index counter
    // ----------------------------------------
    // Strobes are ignored while configuration is done
    assign accept   = slink_cfg_dval && !cfg_done;

    // Index this symbol takes once counted
    assign idx_next = slink_cfg_data.sof ? '0 : idx_q + 9'd1;

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            idx_q <= '0;
        end else if (accept) begin
            idx_q <= idx_next;
        end
    end

    // ----------------------------------------
    // Window test and address decode
    // ----------------------------------------
    assign base = cfg_chaddr_sel ? cfg_info_pkg::frame_index_t'(HDR_LEN_LONG)
                                 : cfg_info_pkg::frame_index_t'(HDR_LEN_SHORT);

    // Byte offset into the table, meaningful only inside the window
    assign win_off = idx_next - base;

    assign in_window = !slink_cfg_data.sof && (idx_next >= base) &&
                       (win_off < cfg_info_pkg::frame_index_t'(cfg_info_pkg::TABLE_BYTES));

    assign wr_ok = accept && in_window;

    // Group number and byte position inside that group
    assign grp_num  = 3'(win_off / cfg_info_pkg::frame_index_t'(cfg_info_pkg::GROUP_BYTES));
    assign grp_byte = 5'(win_off % cfg_info_pkg::frame_index_t'(cfg_info_pkg::GROUP_BYTES));

    // ----------------------------------------
    // Registered write request
    // ----------------------------------------
    // One-hot for a single cycle per accepted byte
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            group_sel <= '0;
        end else if (wr_ok) begin
            group_sel <= cfg_info_pkg::group_sel_t'(1) << grp_num;
        end else begin
            group_sel <= '0;
        end
    end

    // Address and data qualified by group_sel
    always_ff @(posedge clk_sys) begin
        if (wr_ok) begin
            word_index <= cfg_info_pkg::word_index_t'(
                              grp_byte / 5'(cfg_info_pkg::BYTES_PER_WORD));
            byte_lane  <= cfg_info_pkg::byte_lane_t'(
                              grp_byte % 5'(cfg_info_pkg::BYTES_PER_WORD));
            wr_byte    <= slink_cfg_data.data;
        end
    end

endmodule

`default_nettype wire

/* verilog/cfg_info_pkg.sv */
// Layout assumes six groups of six 32-bit words, most significant byte first
`default_nettype none

package cfg_info_pkg;

    // ----------------------------------------
    // Frame layout
    // ----------------------------------------
    localparam int WORDS_PER_GROUP = 6;
    localparam int BYTES_PER_WORD  = 4;
    localparam int NUM_GROUPS      = 6;
    localparam int GROUP_BYTES     = WORDS_PER_GROUP * BYTES_PER_WORD;

    // Bytes of the table window that follows the header
    localparam int TABLE_BYTES     = NUM_GROUPS * GROUP_BYTES;

    // ----------------------------------------
    // Link symbol
    // ----------------------------------------
    typedef struct packed {
        logic       rsvd;
        logic       sof;
        logic [7:0] data;
    } cfg_symbol_t;

    // Symbol position within a frame, start symbol is 0
    typedef logic [8:0] frame_index_t;

    // ----------------------------------------
    // Limit storage
    // ----------------------------------------
    typedef logic [31:0] limit_word_t;
    typedef limit_word_t [WORDS_PER_GROUP-1:0] limit_group_t;

    // First field lands in the top bits of the table
    typedef struct packed {
        limit_group_t engn_ul;
        limit_group_t engn_dl;
        limit_group_t elec_ul;
        limit_group_t elec_dl;
        limit_group_t mnt_ul;
        limit_group_t mnt_dl;
    } limit_table_t;

    // Write addressing
    typedef logic [NUM_GROUPS-1:0] group_sel_t;
    typedef logic [2:0]            word_index_t;
    // Lane 0 is the most significant byte
    typedef logic [1:0]            byte_lane_t;

endpackage

`default_nettype wire
